/* rtl/alu_bus_pkg.sv */
package alu_bus_pkg;

    import alu_ops_pkg::*;

    typedef logic [2:0] wb_adr_t;   // word address.

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        word_t   dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef enum wb_adr_t {
        REG_OPERAND_A = 3'd0,
        REG_OPERAND_B = 3'd1,
        REG_ISSUE     = 3'd2,
        REG_RESULT    = 3'd3,
        REG_STATUS    = 3'd4
    } reg_addr_e;

endpackage

/* rtl/alu_core.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_core
    import alu_ops_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  alu_req_t opq_head_i,
    input  logic     opq_empty_i,
    input  logic     resq_full_i,
    output logic     opq_pop_o,
    output logic     resq_push_o,
    output alu_res_t resq_data_o
);

    localparam int XLEN     = `ALU_XLEN;
    localparam int STEP     = `ALU_COUNT_STEP;
    localparam int NCHUNK   = XLEN / STEP;
    localparam int IDX_W    = (NCHUNK > 1) ? $clog2(NCHUNK) : 1;
    localparam int LAST_IDX = NCHUNK - 1;

    core_state_e      state_q;
    core_state_e      state_d;
    alu_req_t         req_q;
    alu_res_t         res_q;
    logic [IDX_W-1:0] idx_q;
    logic             zdone_q;    // a one bit was already seen by CNTZ.
    word_t            src;
    logic [STEP-1:0]  chunk;
    word_t            chunk_cnt;
    word_t            cnt_sum;
    logic             zero_run;
    logic             md_start;
    logic             md_done;
    word_t            md_result;

    function automatic word_t simple_op(alu_req_t r);
        word_t  res;
        shamt_t sh;
        sh  = r.b[4:0];
        res = '0;
        case (r.opcode)
            OP_AND:   res = r.a & r.b;
            OP_OR:    res = r.a | r.b;
            OP_XOR:   res = r.a ^ r.b;
            OP_SLL:   res = r.a << sh;
            OP_SRL:   res = r.a >> sh;
            OP_SRA:   res = word_t'($signed(r.a) >>> sh);
            OP_SLT:   res = word_t'($signed(r.a) < $signed(r.b));
            OP_SLTU:  res = word_t'(r.a < r.b);
            OP_ADD:   res = r.a + r.b;
            OP_SUB:   res = r.a - r.b;
            OP_PKG:   res = {r.b[XLEN-1:XLEN/2], r.a[XLEN/2-1:0]};
            OP_SLADD: res = {r.a[XLEN-2:0], 1'b0} + r.b;
            OP_RVRS: begin
                for (int i = 0; i < XLEN; i++) begin
                    res[i] = r.a[XLEN-1-i];
                end
            end
            default:  res = '0;   // counting ops start from zero.
        endcase
        return res;
    endfunction

    assign src   = (req_q.opcode == OP_HMDST) ? (req_q.a ^ req_q.b) : req_q.a;
    assign chunk = src[idx_q*STEP +: STEP];

    always_comb begin
        chunk_cnt = '0;
        zero_run  = !zdone_q;
        for (int i = 0; i < STEP; i++) begin
            if (req_q.opcode == OP_CNTZ) begin
                if (chunk[i]) begin
                    zero_run = 1'b0;
                end else if (zero_run) begin
                    chunk_cnt = chunk_cnt + word_t'(1);
                end
            end else begin
                chunk_cnt = chunk_cnt + word_t'(chunk[i]);
            end
        end
    end

    assign cnt_sum = res_q.result + chunk_cnt;   // shared accumulator adder.

    always_comb begin
        state_d     = state_q;
        opq_pop_o   = 1'b0;
        md_start    = 1'b0;
        resq_push_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (!opq_empty_i) begin
                    opq_pop_o = 1'b1;
                    if (opq_head_i.opcode inside {OP_CNTZ, OP_CNTP, OP_HMDST}) begin
                        state_d = ST_COUNT;
                    end else if (opq_head_i.opcode inside {[OP_MUL:OP_REMU]}) begin
                        md_start = 1'b1;
                        state_d  = ST_MULDIV;
                    end else begin
                        state_d = ST_PUSH;
                    end
                end
            end
            ST_COUNT:  state_d = (idx_q == IDX_W'(LAST_IDX)) ? ST_PUSH : ST_COUNT;
            ST_MULDIV: state_d = md_done ? ST_PUSH : ST_MULDIV;
            ST_PUSH: begin
                if (!resq_full_i) begin
                    resq_push_o = 1'b1;
                    state_d     = ST_IDLE;
                end
            end
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
            zdone_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_COUNT) begin
                idx_q   <= idx_q + IDX_W'(1);
                zdone_q <= zdone_q || (|chunk);
            end else begin
                idx_q   <= '0;
                zdone_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (opq_pop_o) begin
            req_q        <= opq_head_i;
            res_q.result <= simple_op(opq_head_i);
            res_q.eq     <= (opq_head_i.a == opq_head_i.b);
            res_q.lt     <= ($signed(opq_head_i.a) < $signed(opq_head_i.b));
            res_q.ltu    <= (opq_head_i.a < opq_head_i.b);
        end else if (state_q == ST_COUNT) begin
            res_q.result <= cnt_sum;
        end else if (state_q == ST_MULDIV && md_done) begin
            res_q.result <= md_result;
        end
    end

    assign resq_data_o = res_q;

    alu_muldiv u_muldiv (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .start_i  (md_start),
        .opcode_i (opq_head_i.opcode),
        .a_i      (opq_head_i.a),
        .b_i      (opq_head_i.b),
        .done_o   (md_done),
        .result_o (md_result)
    );

endmodule

/* rtl/alu_muldiv.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_muldiv
    import alu_ops_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        start_i,
    input  alu_opcode_e opcode_i,
    input  word_t       a_i,
    input  word_t       b_i,
    output logic        done_o,
    output word_t       result_o
);

    localparam int XLEN  = `ALU_XLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    alu_opcode_e      op_q;
    dword_t           acc_q;      // product, or remainder over quotient.
    word_t            opnd_q;     // multiplicand or divisor magnitude.
    word_t            a_q;
    logic             neg_q;
    logic             b_zero_q;
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             signed_op;
    logic             start_mul;
    logic             a_neg;
    logic             b_neg;
    word_t            a_mag;
    word_t            b_mag;
    word_t            mul_add;
    logic [XLEN:0]    mul_sum;
    logic [XLEN:0]    div_part;
    logic [XLEN:0]    div_trial;
    dword_t           prod_fix;
    word_t            quo_fix;
    word_t            rem_fix;

    assign signed_op = opcode_i inside {OP_MUL, OP_MULH, OP_DIV, OP_REM};
    assign start_mul = opcode_i inside {OP_MUL, OP_MULH};
    assign a_neg     = signed_op && a_i[XLEN-1];
    assign b_neg     = signed_op && b_i[XLEN-1];
    assign a_mag     = a_neg ? -a_i : a_i;
    assign b_mag     = b_neg ? -b_i : b_i;

    assign mul_add   = acc_q[0] ? opnd_q : '0;
    assign mul_sum   = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, mul_add};
    assign div_part  = acc_q[2*XLEN-1:XLEN-1];   // remainder with next dividend bit.
    assign div_trial = div_part - {1'b0, opnd_q};

    assign done_o = busy_q && (cnt_q == CNT_W'(XLEN));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i && !busy_q) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (done_o) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + CNT_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && !busy_q) begin
            op_q     <= opcode_i;
            a_q      <= a_i;
            b_zero_q <= (b_i == '0);
            neg_q    <= (opcode_i == OP_REM) ? a_neg : (a_neg ^ b_neg);
            acc_q    <= start_mul ? {{XLEN{1'b0}}, b_mag} : {{XLEN{1'b0}}, a_mag};
            opnd_q   <= start_mul ? a_mag : b_mag;
        end else if (busy_q && !done_o) begin
            if (op_q inside {OP_MUL, OP_MULH}) begin
                acc_q <= {mul_sum, acc_q[XLEN-1:1]};
            end else if (!div_trial[XLEN]) begin
                acc_q <= {div_trial[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
            end else begin
                acc_q <= {div_part[XLEN-1:0], acc_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // most negative over minus one needs no special case here.
    assign prod_fix = neg_q ? -acc_q : acc_q;
    assign quo_fix  = neg_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
    assign rem_fix  = neg_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];

    always_comb begin
        case (op_q)
            OP_MUL:          result_o = prod_fix[XLEN-1:0];
            OP_MULH:         result_o = prod_fix[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU: result_o = b_zero_q ? '1 : quo_fix;
            default:         result_o = b_zero_q ? a_q : rem_fix;
        endcase
    end

endmodule

/* rtl/alu_ops_pkg.sv */
`include "alu_settings.svh"

package alu_ops_pkg;

    typedef logic [`ALU_XLEN-1:0]   word_t;
    typedef logic [2*`ALU_XLEN-1:0] dword_t;   // full product.
    typedef logic [4:0]             shamt_t;

    typedef enum logic [4:0] {
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_MULH,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU,
        OP_HMDST,   // popcount of a xor b.
        OP_PKG,
        OP_RVRS,
        OP_SLADD,
        OP_CNTZ,
        OP_CNTP
    } alu_opcode_e;

    typedef struct packed {
        alu_opcode_e opcode;
        word_t       a;
        word_t       b;
    } alu_req_t;

    typedef struct packed {
        word_t result;
        logic  eq;
        logic  lt;    // signed.
        logic  ltu;
    } alu_res_t;

    typedef enum logic [1:0] {ST_IDLE, ST_COUNT, ST_MULDIV, ST_PUSH} core_state_e;

endpackage

/* rtl/alu_queue.sv */
`timescale 1ns/100ps

module alu_queue #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output T     head_o,
    output logic full_o,
    output logic empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;   // none, or both at once.
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    assign head_o  = mem[rd_ptr_q];
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

endmodule

/* rtl/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// data word width.
`define ALU_XLEN 32

// bits examined per cycle by CNTZ, CNTP and HMDST; divides ALU_XLEN.
`define ALU_COUNT_STEP 8

// entries in each of the two queues.
`define ALU_QUEUE_DEPTH 4

`endif

/* rtl/alu_subsystem.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_subsystem
    import alu_ops_pkg::*;
    import alu_bus_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    alu_req_t opq_data;
    alu_req_t opq_head;
    logic     opq_push;
    logic     opq_pop;
    logic     opq_full;
    logic     opq_empty;
    alu_res_t resq_data;
    alu_res_t resq_head;
    logic     resq_push;
    logic     resq_pop;
    logic     resq_full;
    logic     resq_empty;

    alu_wb_slave u_wb_slave (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .wb_req_i     (wb_req_i),
        .opq_full_i   (opq_full),
        .resq_head_i  (resq_head),
        .resq_empty_i (resq_empty),
        .wb_rsp_o     (wb_rsp_o),
        .opq_push_o   (opq_push),
        .opq_data_o   (opq_data),
        .resq_pop_o   (resq_pop)
    );

    alu_queue #(.T(alu_req_t), .DEPTH(`ALU_QUEUE_DEPTH)) u_op_queue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .push_i      (opq_push),
        .push_data_i (opq_data),
        .pop_i       (opq_pop),
        .head_o      (opq_head),
        .full_o      (opq_full),
        .empty_o     (opq_empty)
    );

    alu_queue #(.T(alu_res_t), .DEPTH(`ALU_QUEUE_DEPTH)) u_res_queue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .push_i      (resq_push),
        .push_data_i (resq_data),
        .pop_i       (resq_pop),
        .head_o      (resq_head),
        .full_o      (resq_full),
        .empty_o     (resq_empty)
    );

    alu_core u_core (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .opq_head_i  (opq_head),
        .opq_empty_i (opq_empty),
        .resq_full_i (resq_full),
        .opq_pop_o   (opq_pop),
        .resq_push_o (resq_push),
        .resq_data_o (resq_data)
    );

endmodule

/* rtl/alu_wb_slave.sv */
`timescale 1ns/100ps

module alu_wb_slave
    import alu_ops_pkg::*;
    import alu_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  wb_req_t  wb_req_i,
    input  logic     opq_full_i,
    input  alu_res_t resq_head_i,
    input  logic     resq_empty_i,
    output wb_rsp_t  wb_rsp_o,
    output logic     opq_push_o,
    output alu_req_t opq_data_o,
    output logic     resq_pop_o
);

    word_t     opnd_a_q;
    word_t     opnd_b_q;
    word_t     rdata_q;
    word_t     status;
    logic      ack_q;
    logic      access;
    logic      ready;
    logic      accept;
    reg_addr_e reg_sel;

    assign reg_sel = reg_addr_e'(wb_req_i.adr);
    assign access  = wb_req_i.cyc && wb_req_i.stb && !ack_q;   // one access per ack.

    // issue waits for room, result readout waits for data.
    always_comb begin
        case (reg_sel)
            REG_ISSUE:  ready = !wb_req_i.we || !opq_full_i;
            REG_RESULT: ready = wb_req_i.we || !resq_empty_i;
            default:    ready = 1'b1;
        endcase
    end

    assign accept     = access && ready;
    assign opq_push_o = accept && wb_req_i.we && (reg_sel == REG_ISSUE);
    assign resq_pop_o = accept && !wb_req_i.we && (reg_sel == REG_RESULT);
    assign opq_data_o = '{opcode: alu_opcode_e'(wb_req_i.dat[4:0]), a: opnd_a_q, b: opnd_b_q};

    always_comb begin
        status    = '0;
        status[0] = !resq_empty_i;
        status[1] = opq_full_i;
        if (!resq_empty_i) begin
            status[4] = resq_head_i.eq;
            status[5] = resq_head_i.lt;
            status[6] = resq_head_i.ltu;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && wb_req_i.we) begin
            if (reg_sel == REG_OPERAND_A) begin
                opnd_a_q <= wb_req_i.dat;
            end
            if (reg_sel == REG_OPERAND_B) begin
                opnd_b_q <= wb_req_i.dat;
            end
        end
        if (accept && !wb_req_i.we) begin
            case (reg_sel)
                REG_RESULT: rdata_q <= resq_head_i.result;
                REG_STATUS: rdata_q <= status;
                default:    rdata_q <= '0;   // write-only or unmapped.
            endcase
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};

endmodule

/* run.sh */
#!/bin/sh
# Builds and runs the ALU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f sources.f --top-module alu_tb -o alu_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/alu_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+rtl
rtl/alu_ops_pkg.sv
rtl/alu_bus_pkg.sv
rtl/alu_queue.sv
rtl/alu_muldiv.sv
rtl/alu_wb_slave.sv
rtl/alu_core.sv
rtl/alu_subsystem.sv
tests/alu_checker.sv
tests/alu_tb.sv

/* tests/alu_checker.sv */
`timescale 1ns/100ps

module alu_checker
    import alu_bus_pkg::*;
(
    input logic    clk_i,
    input logic    rstn_i,
    input wb_req_t wb_req_i,
    input wb_rsp_t wb_rsp_i
);

    logic bus_strobe;

    assign bus_strobe = wb_req_i.cyc && wb_req_i.stb;

    // ack comes from a register that clears with reset.
    ack_low_after_reset: assert property (
        @(posedge clk_i) !rstn_i |=> !wb_rsp_i.ack
    ) else $error("ack high in the cycle after reset");

    ack_needs_strobe: assert property (
        @(posedge clk_i) disable iff (!rstn_i) wb_rsp_i.ack |-> bus_strobe
    ) else $error("ack high while cyc or stb is low");

    ack_single_cycle: assert property (
        @(posedge clk_i) disable iff (!rstn_i) wb_rsp_i.ack |=> !wb_rsp_i.ack
    ) else $error("ack high for two consecutive cycles");

endmodule

/* tests/alu_tb.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_tb
    import alu_ops_pkg::*;
    import alu_bus_pkg::*;
();

    localparam int     XLEN      = `ALU_XLEN;
    localparam int     NUM_OPS   = 22;
    localparam int     BURST     = `ALU_QUEUE_DEPTH * 2 + 1;
    localparam int     N_RAND    = 200;
    localparam int     N_COUNT   = 20;
    localparam int     N_MULDIV  = 40;
    localparam int     N_FLAGS   = 6;
    localparam int     TOTAL_OPS = N_RAND * 13 + (N_COUNT + 2) * 3
                                   + (N_MULDIV + 2) * 6 + N_FLAGS + BURST;
    localparam longint WATCHDOG_NS = longint'(TOTAL_OPS) * (XLEN + 10) * 8 + 20000;
    localparam word_t  MOST_NEG  = word_t'(1) << (XLEN - 1);

    logic    clk = 1'b0;
    logic    rstn;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    int      error_count;
    int      tests_passed;
    int      tests_failed;

    always #4 clk = ~clk;

    alu_subsystem u_alu_subsystem (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    bind alu_subsystem alu_checker u_checker (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_req_i (wb_req_i),
        .wb_rsp_i (wb_rsp_o)
    );

    // expected result and flags for one request.
    function automatic alu_res_t model_op(alu_opcode_e op, word_t a, word_t b);
        alu_res_t r;
        longint   sa;
        longint   sb;
        dword_t   prod;
        word_t    x;
        int       n;
        sa       = longint'($signed(a));
        sb       = longint'($signed(b));
        prod     = dword_t'(sa * sb);
        x        = (op == OP_HMDST) ? (a ^ b) : a;
        n        = 0;
        r.result = '0;
        r.eq     = (a == b);
        r.lt     = (sa < sb);
        r.ltu    = (a < b);
        case (op)
            OP_AND:   r.result = a & b;
            OP_OR:    r.result = a | b;
            OP_XOR:   r.result = a ^ b;
            OP_SLL:   r.result = a << b[4:0];
            OP_SRL:   r.result = a >> b[4:0];
            OP_SRA:   r.result = word_t'(sa >>> b[4:0]);
            OP_SLT:   r.result = (sa < sb) ? word_t'(1) : '0;
            OP_SLTU:  r.result = (a < b) ? word_t'(1) : '0;
            OP_ADD:   r.result = a + b;
            OP_SUB:   r.result = a - b;
            OP_MUL:   r.result = prod[XLEN-1:0];
            OP_MULH:  r.result = prod[2*XLEN-1:XLEN];
            OP_DIV: begin
                if (b == '0) r.result = '1;
                else if (a == MOST_NEG && b == '1) r.result = MOST_NEG;
                else r.result = word_t'(sa / sb);
            end
            OP_DIVU:  r.result = (b == '0) ? '1 : a / b;
            OP_REM: begin
                if (b == '0) r.result = a;
                else if (a == MOST_NEG && b == '1) r.result = '0;
                else r.result = word_t'(sa % sb);
            end
            OP_REMU:  r.result = (b == '0) ? a : a % b;
            OP_HMDST, OP_CNTP: begin
                for (int i = 0; i < XLEN; i++) n = n + (x[i] ? 1 : 0);
                r.result = word_t'(n);
            end
            OP_CNTZ: begin
                while (n < XLEN && a[n] == 1'b0) n++;
                r.result = word_t'(n);
            end
            OP_PKG:   r.result = {b[XLEN-1:XLEN/2], a[XLEN/2-1:0]};
            OP_RVRS:  for (int i = 0; i < XLEN; i++) r.result[i] = a[XLEN-1-i];
            OP_SLADD: r.result = (a << 1) + b;
            default:  r.result = '0;
        endcase
        return r;
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // called on a falling edge, returns on a falling edge.
    task automatic bus_access(input logic we, input wb_adr_t adr, input word_t wdat,
                              output word_t rdat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!wb_rsp.ack) @(negedge clk);
        rdat = wb_rsp.dat;
        @(negedge clk);   // stb held through the ack cycle.
        wb_req = '0;
    endtask

    task automatic bus_write(wb_adr_t adr, word_t dat);
        word_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input wb_adr_t adr, output word_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic run_op(string name, alu_opcode_e op, word_t a, word_t b);
        alu_res_t exp;
        word_t    got;
        exp = model_op(op, a, b);
        bus_write(REG_OPERAND_A, a);
        bus_write(REG_OPERAND_B, b);
        bus_write(REG_ISSUE, word_t'(op));
        bus_read(REG_RESULT, got);
        check_value($sformatf("%s %s", name, op.name()), exp.result, got);
    endtask

    task automatic check_flags(string name, word_t a, word_t b);
        alu_res_t exp;
        word_t    status;
        word_t    got;
        exp    = model_op(OP_SUB, a, b);
        status = '0;
        bus_write(REG_OPERAND_A, a);
        bus_write(REG_OPERAND_B, b);
        bus_write(REG_ISSUE, word_t'(OP_SUB));
        while (!status[0]) bus_read(REG_STATUS, status);
        check_value({name, " status"}, word_t'({exp.ltu, exp.lt, exp.eq}), word_t'(status[6:4]));
        bus_read(REG_RESULT, got);
        check_value({name, " result"}, exp.result, got);
    endtask

    task automatic finish_test(string name, int mark);
        if (error_count == mark) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - mark);
        end
    endtask

    initial begin
        int          mark;
        word_t       a;
        word_t       b;
        word_t       status;
        word_t       got;
        alu_opcode_e op;
        alu_res_t    exp;
        alu_res_t    burst_exp[$];
        rstn         = 1'b0;
        wb_req       = '0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'hae38_ec26));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        mark = error_count;
        bus_read(REG_STATUS, status);
        check_value("reset_status", '0, status & 32'h3);
        finish_test("reset_status", mark);

        mark = error_count;
        for (int i = 0; i < N_RAND; i++) begin
            a = $urandom();
            b = $urandom();
            for (int k = 0; k < NUM_OPS; k++) begin
                op = alu_opcode_e'(k);
                if (!(op inside {[OP_MUL:OP_REMU], OP_HMDST, OP_CNTZ, OP_CNTP})) begin
                    run_op("single_cycle", op, a, b);
                end
            end
        end
        finish_test("single_cycle", mark);

        mark = error_count;
        for (int i = 0; i < N_COUNT + 2; i++) begin
            a = $urandom() << ($urandom() % XLEN);   // varied trailing zeros.
            b = $urandom();
            if (i == N_COUNT) begin
                a = '0;
                b = '1;
            end
            if (i == N_COUNT + 1) begin
                a = '1;
                b = '1;
            end
            run_op("count", OP_CNTZ, a, b);
            run_op("count", OP_CNTP, a, b);
            run_op("count", OP_HMDST, a, b);
        end
        finish_test("count", mark);

        mark = error_count;
        for (int i = 0; i < N_MULDIV + 2; i++) begin
            a = $urandom();
            b = $urandom();
            if (i % 3 == 1) b = word_t'($signed(b) >>> ($urandom() % XLEN));
            if (i == N_MULDIV) b = '0;
            if (i == N_MULDIV + 1) begin
                a = MOST_NEG;
                b = '1;
            end
            for (int k = int'(OP_MUL); k <= int'(OP_REMU); k++) begin
                run_op("muldiv", alu_opcode_e'(k), a, b);
            end
        end
        finish_test("muldiv", mark);

        mark = error_count;
        a = $urandom();
        check_flags("flags equal", a, a);
        a = $urandom() | MOST_NEG;
        b = $urandom() & ~MOST_NEG;
        check_flags("flags neg_pos", a, b);
        check_flags("flags pos_neg", b, a);
        for (int i = 0; i < N_FLAGS - 3; i++) check_flags("flags random", $urandom(), $urandom());
        finish_test("flags", mark);

        mark = error_count;
        for (int i = 0; i < BURST; i++) begin
            op = alu_opcode_e'($urandom() % NUM_OPS);
            a  = $urandom();
            b  = $urandom();
            burst_exp.push_back(model_op(op, a, b));
            bus_write(REG_OPERAND_A, a);
            bus_write(REG_OPERAND_B, b);
            bus_write(REG_ISSUE, word_t'(op));
        end
        for (int i = 0; i < BURST; i++) begin
            bus_read(REG_RESULT, got);
            exp = burst_exp.pop_front();
            check_value($sformatf("burst %0d", i), exp.result, got);
        end
        finish_test("burst", mark);

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule
